// File: common/cpu_types_pkg.sv
package cpu_types_pkg;

	// ##############################
	// widths and basic types.
	// ##############################

	localparam int XLEN = 32;
	localparam int TAG_SIZE = 2;

	typedef logic [TAG_SIZE-1:0] tag_t;
	typedef logic [4:0] reg_index_t;

	// ##############################
	// instruction encodings.
	// ##############################

	localparam logic [6:0] OPCODE_OP = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI = 7'b0110111;

	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_SLL = 3'b001;
	localparam logic [2:0] FUNCT3_SLT = 3'b010;
	localparam logic [2:0] FUNCT3_SLTU = 3'b011;
	localparam logic [2:0] FUNCT3_XOR = 3'b100;
	localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
	localparam logic [2:0] FUNCT3_OR = 3'b110;
	localparam logic [2:0] FUNCT3_AND = 3'b111;

	// alt form selects SUB and SRA/SRAI.
	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	// ##############################
	// alu operations.
	// ##############################

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_e;

endpackage

// File: registers/cpu_registers.sv
module cpu_registers #(
	parameter logic [cpu_types_pkg::XLEN-1:0] STACK_POINTER = '0
)(
	input logic i_clock,
	input logic i_reset,

	input cpu_types_pkg::reg_index_t i_rs1_index,
	input cpu_types_pkg::reg_index_t i_rs2_index,

	input cpu_types_pkg::reg_index_t i_wb_rd,
	input logic [cpu_types_pkg::XLEN-1:0] i_wb_value,
	input cpu_types_pkg::tag_t i_wb_tag,

	output logic [cpu_types_pkg::XLEN-1:0] o_rs1,
	output logic [cpu_types_pkg::XLEN-1:0] o_rs2
);

	logic [cpu_types_pkg::XLEN-1:0] regs [32];
	cpu_types_pkg::tag_t write_tag;

	// ##############################
	// read ports.
	// ##############################

	// x0 is forced to zero on read.
	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_rs1 <= '0;
			o_rs2 <= '0;
		end else begin
			o_rs1 <= (i_rs1_index != '0) ? regs[i_rs1_index] : '0;
			o_rs2 <= (i_rs2_index != '0) ? regs[i_rs2_index] : '0;
		end
	end

	// ##############################
	// tag-gated write port.
	// ##############################

	// a new tag marks a new writeback; a repeated tag is the same one seen again.
	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			write_tag <= '0;
			for (int i = 0; i < 32; i++) begin
				regs[i] <= (i == 2) ? STACK_POINTER : '0;
			end
		end else if (i_wb_tag != write_tag) begin
			if (i_wb_rd != '0) begin
				regs[i_wb_rd] <= i_wb_value;
			end
			write_tag <= i_wb_tag;
		end
	end

endmodule

// File: decode/cpu_immediate.sv
module cpu_immediate (
	input logic i_clock,
	input logic i_reset,

	input logic [31:0] i_inst,

	output logic [cpu_types_pkg::XLEN-1:0] o_imm,
	output logic o_use_imm,
	output cpu_types_pkg::alu_op_e o_alu_op,
	output cpu_types_pkg::reg_index_t o_rd,
	output logic o_illegal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [cpu_types_pkg::XLEN-1:0] imm_i;
	logic [cpu_types_pkg::XLEN-1:0] imm_shift;
	logic [cpu_types_pkg::XLEN-1:0] imm_u;
	logic is_shift;
	logic alt;

	logic [cpu_types_pkg::XLEN-1:0] next_imm;
	logic next_use_imm;
	cpu_types_pkg::alu_op_e next_alu_op;
	cpu_types_pkg::reg_index_t next_rd;
	logic next_illegal;

	// same funct3 mapping serves OP and OP-IMM.
	function automatic cpu_types_pkg::alu_op_e base_op(input logic [2:0] f3,
		input logic use_alt);
		case (f3)
			cpu_types_pkg::FUNCT3_ADD_SUB: begin
				return use_alt ? cpu_types_pkg::ALU_SUB : cpu_types_pkg::ALU_ADD;
			end
			cpu_types_pkg::FUNCT3_SLL: return cpu_types_pkg::ALU_SLL;
			cpu_types_pkg::FUNCT3_SLT: return cpu_types_pkg::ALU_SLT;
			cpu_types_pkg::FUNCT3_SLTU: return cpu_types_pkg::ALU_SLTU;
			cpu_types_pkg::FUNCT3_XOR: return cpu_types_pkg::ALU_XOR;
			cpu_types_pkg::FUNCT3_SRL_SRA: begin
				return use_alt ? cpu_types_pkg::ALU_SRA : cpu_types_pkg::ALU_SRL;
			end
			cpu_types_pkg::FUNCT3_OR: return cpu_types_pkg::ALU_OR;
			default: return cpu_types_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];
	assign alt = (funct7 == cpu_types_pkg::FUNCT7_ALT);
	assign is_shift = (funct3 == cpu_types_pkg::FUNCT3_SLL) ||
		(funct3 == cpu_types_pkg::FUNCT3_SRL_SRA);

	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_shift = {27'b0, i_inst[24:20]};
	assign imm_u = {i_inst[31:12], 12'b0};

	always_comb begin
		next_imm = '0;
		next_use_imm = 1'b0;
		next_alu_op = cpu_types_pkg::ALU_ADD;
		next_rd = i_inst[11:7];
		next_illegal = 1'b0;

		case (opcode)
			cpu_types_pkg::OPCODE_OP: begin
				next_alu_op = base_op(funct3, alt);
				next_illegal = !((funct7 == cpu_types_pkg::FUNCT7_BASE) ||
					(alt && (funct3 == cpu_types_pkg::FUNCT3_ADD_SUB ||
					funct3 == cpu_types_pkg::FUNCT3_SRL_SRA)));
			end
			cpu_types_pkg::OPCODE_OP_IMM: begin
				next_use_imm = 1'b1;
				if (is_shift) begin
					next_imm = imm_shift;
					next_alu_op = base_op(funct3, alt);
					next_illegal = !((funct7 == cpu_types_pkg::FUNCT7_BASE) ||
						(alt && funct3 == cpu_types_pkg::FUNCT3_SRL_SRA));
				end else begin
					// there is no SUBI and the alt form never applies here.
					next_imm = imm_i;
					next_alu_op = base_op(funct3, 1'b0);
				end
			end
			cpu_types_pkg::OPCODE_LUI: begin
				next_imm = imm_u;
				next_use_imm = 1'b1;
				next_alu_op = cpu_types_pkg::ALU_PASS_B;
			end
			default: begin
				next_illegal = 1'b1;
			end
		endcase

		// illegal instructions never target a register.
		if (next_illegal) begin
			next_rd = '0;
		end
	end

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_imm <= '0;
			o_use_imm <= 1'b0;
			o_alu_op <= cpu_types_pkg::ALU_ADD;
			o_rd <= '0;
			o_illegal <= 1'b0;
		end else begin
			o_imm <= next_imm;
			o_use_imm <= next_use_imm;
			o_alu_op <= next_alu_op;
			o_rd <= next_rd;
			o_illegal <= next_illegal;
		end
	end

endmodule

// File: source/cpu_execute.sv
module cpu_execute (
	input logic i_clock,
	input logic i_reset,

	input logic [cpu_types_pkg::XLEN-1:0] i_rs1,
	input logic [cpu_types_pkg::XLEN-1:0] i_rs2,
	input logic [cpu_types_pkg::XLEN-1:0] i_imm,
	input logic i_use_imm,
	input cpu_types_pkg::alu_op_e i_alu_op,
	input cpu_types_pkg::reg_index_t i_rd,
	input logic i_illegal,
	input cpu_types_pkg::tag_t i_tag,

	output logic [cpu_types_pkg::XLEN-1:0] o_result,
	output cpu_types_pkg::reg_index_t o_rd,
	output logic o_illegal,
	output cpu_types_pkg::tag_t o_tag
);

	logic [cpu_types_pkg::XLEN-1:0] operand_a;
	logic [cpu_types_pkg::XLEN-1:0] operand_b;
	logic [4:0] shamt;
	logic [cpu_types_pkg::XLEN-1:0] alu_result;

	assign operand_a = i_rs1;
	assign operand_b = i_use_imm ? i_imm : i_rs2;
	assign shamt = operand_b[4:0];

	// ##############################
	// alu.
	// ##############################

	always_comb begin
		case (i_alu_op)
			cpu_types_pkg::ALU_ADD: alu_result = operand_a + operand_b;
			cpu_types_pkg::ALU_SUB: alu_result = operand_a - operand_b;
			cpu_types_pkg::ALU_XOR: alu_result = operand_a ^ operand_b;
			cpu_types_pkg::ALU_OR: alu_result = operand_a | operand_b;
			cpu_types_pkg::ALU_AND: alu_result = operand_a & operand_b;
			cpu_types_pkg::ALU_SLL: alu_result = operand_a << shamt;
			cpu_types_pkg::ALU_SRL: alu_result = operand_a >> shamt;
			cpu_types_pkg::ALU_SRA: alu_result = $signed(operand_a) >>> shamt;
			cpu_types_pkg::ALU_SLT: begin
				alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
			end
			cpu_types_pkg::ALU_SLTU: begin
				alu_result = {31'b0, operand_a < operand_b};
			end
			cpu_types_pkg::ALU_PASS_B: alu_result = operand_b;
			default: alu_result = '0;
		endcase
	end

	// ##############################
	// result register.
	// ##############################

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_result <= '0;
			o_rd <= '0;
			o_illegal <= 1'b0;
			o_tag <= '0;
		end else begin
			// illegal instructions give a zero result.
			o_result <= i_illegal ? '0 : alu_result;
			o_rd <= i_rd;
			o_illegal <= i_illegal;
			o_tag <= i_tag;
		end
	end

endmodule

// File: source/cpu_operand_stage.sv
module cpu_operand_stage #(
	parameter logic [cpu_types_pkg::XLEN-1:0] STACK_POINTER = 32'h0000_8000
)(
	input logic i_clock,
	input logic i_reset,

	input logic [31:0] i_fetch_inst,
	input cpu_types_pkg::tag_t i_fetch_tag,

	input cpu_types_pkg::reg_index_t i_wb_rd,
	input logic [cpu_types_pkg::XLEN-1:0] i_wb_value,
	input cpu_types_pkg::tag_t i_wb_tag,

	output logic [cpu_types_pkg::XLEN-1:0] o_result,
	output cpu_types_pkg::reg_index_t o_rd,
	output logic o_illegal,
	output cpu_types_pkg::tag_t o_tag
);

	logic [cpu_types_pkg::XLEN-1:0] rs1;
	logic [cpu_types_pkg::XLEN-1:0] rs2;
	logic [cpu_types_pkg::XLEN-1:0] imm;
	logic use_imm;
	cpu_types_pkg::alu_op_e alu_op;
	cpu_types_pkg::reg_index_t rd;
	logic illegal;
	cpu_types_pkg::tag_t fetch_tag_q;

	cpu_registers #(
		.STACK_POINTER(STACK_POINTER)
	) u_registers (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_index(i_fetch_inst[19:15]),
		.i_rs2_index(i_fetch_inst[24:20]),
		.i_wb_rd(i_wb_rd),
		.i_wb_value(i_wb_value),
		.i_wb_tag(i_wb_tag),
		.o_rs1(rs1),
		.o_rs2(rs2)
	);

	cpu_immediate u_immediate (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_inst(i_fetch_inst),
		.o_imm(imm),
		.o_use_imm(use_imm),
		.o_alu_op(alu_op),
		.o_rd(rd),
		.o_illegal(illegal)
	);

	// tag follows the register read and decode by one cycle.
	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			fetch_tag_q <= '0;
		end else begin
			fetch_tag_q <= i_fetch_tag;
		end
	end

	cpu_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_imm(imm),
		.i_use_imm(use_imm),
		.i_alu_op(alu_op),
		.i_rd(rd),
		.i_illegal(illegal),
		.i_tag(fetch_tag_q),
		.o_result(o_result),
		.o_rd(o_rd),
		.o_illegal(o_illegal),
		.o_tag(o_tag)
	);

endmodule

// File: verif/cpu_operand_stage_chk.sv
module cpu_operand_stage_chk (
	input logic i_clock,
	input logic i_reset,
	input cpu_types_pkg::reg_index_t i_rs1_index,
	input cpu_types_pkg::reg_index_t i_rs2_index,
	input logic [cpu_types_pkg::XLEN-1:0] i_rs1,
	input logic [cpu_types_pkg::XLEN-1:0] i_rs2
);

	int failures = 0;

	// ##############################
	// x0 reads.
	// ##############################

	rs1_x0_zero: assert property (@(posedge i_clock) disable iff (i_reset)
		($past(i_rs1_index) == '0) |-> (i_rs1 == '0))
	else begin
		failures++;
		$error("rs1 read of x0 is not zero");
	end

	rs2_x0_zero: assert property (@(posedge i_clock) disable iff (i_reset)
		($past(i_rs2_index) == '0) |-> (i_rs2 == '0))
	else begin
		failures++;
		$error("rs2 read of x0 is not zero");
	end

	// read outputs still hold their reset value on the first edge out of reset.
	reset_outputs_zero: assert property (@(posedge i_clock)
		$fell(i_reset) |-> (i_rs1 == '0 && i_rs2 == '0))
	else begin
		failures++;
		$error("read outputs not zero after reset");
	end

endmodule

// File: verif/cpu_operand_stage_tb.sv
module cpu_operand_stage_tb;

	localparam int CLOCK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int MAX_ROWS = 96;
	localparam logic [31:0] STACK_POINTER = 32'h0000_8000;
	localparam logic [6:0] OPCODE_STORE = 7'b0100011;

	// source registers for the random operations.
	localparam cpu_types_pkg::reg_index_t SOURCES [8] = '{
		5'd2, 5'd8, 5'd14, 5'd15, 5'd16, 5'd17, 5'd18, 5'd19
	};

	logic clock;
	logic reset;
	logic [31:0] fetch_inst;
	cpu_types_pkg::tag_t fetch_tag;
	cpu_types_pkg::reg_index_t wb_rd;
	logic [31:0] wb_value;
	cpu_types_pkg::tag_t wb_tag;
	logic [31:0] dut_result;
	cpu_types_pkg::reg_index_t dut_rd;
	logic dut_illegal;
	cpu_types_pkg::tag_t dut_tag;

	// stimulus table.
	logic [31:0] row_inst [MAX_ROWS];
	logic row_wb_new [MAX_ROWS];
	cpu_types_pkg::reg_index_t row_wb_rd [MAX_ROWS];
	logic [31:0] row_wb_value [MAX_ROWS];
	int row_count;

	// expected values, filled in by the model as rows are applied.
	logic [31:0] exp_result [MAX_ROWS];
	cpu_types_pkg::reg_index_t exp_rd [MAX_ROWS];
	logic exp_illegal [MAX_ROWS];
	cpu_types_pkg::tag_t exp_tag [MAX_ROWS];

	logic [31:0] model_regs [32];
	logic [31:0] rng_state;

	cpu_operand_stage #(
		.STACK_POINTER(STACK_POINTER)
	) i_cpu_operand_stage (
		.i_clock(clock),
		.i_reset(reset),
		.i_fetch_inst(fetch_inst),
		.i_fetch_tag(fetch_tag),
		.i_wb_rd(wb_rd),
		.i_wb_value(wb_value),
		.i_wb_tag(wb_tag),
		.o_result(dut_result),
		.o_rd(dut_rd),
		.o_illegal(dut_illegal),
		.o_tag(dut_tag)
	);

	bind cpu_registers cpu_operand_stage_chk u_chk (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_index(i_rs1_index),
		.i_rs2_index(i_rs2_index),
		.i_rs1(o_rs1),
		.i_rs2(o_rs2)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// ##############################
	// helpers.
	// ##############################

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	function automatic logic [31:0] make_r_type(input logic [6:0] funct7,
		input cpu_types_pkg::reg_index_t rs2, input cpu_types_pkg::reg_index_t rs1,
		input logic [2:0] funct3, input cpu_types_pkg::reg_index_t rd);
		return {funct7, rs2, rs1, funct3, rd, cpu_types_pkg::OPCODE_OP};
	endfunction

	function automatic logic [31:0] make_i_type(input logic [11:0] imm,
		input cpu_types_pkg::reg_index_t rs1, input logic [2:0] funct3,
		input cpu_types_pkg::reg_index_t rd);
		return {imm, rs1, funct3, rd, cpu_types_pkg::OPCODE_OP_IMM};
	endfunction

	function automatic logic [31:0] make_lui(input logic [19:0] imm,
		input cpu_types_pkg::reg_index_t rd);
		return {imm, rd, cpu_types_pkg::OPCODE_LUI};
	endfunction

	// store word is not supported by the slice.
	function automatic logic [31:0] make_store(input cpu_types_pkg::reg_index_t rs2,
		input cpu_types_pkg::reg_index_t rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPCODE_STORE};
	endfunction

	// ##############################
	// reference model.
	// ##############################

	function automatic logic model_illegal(input logic [31:0] inst);
		return !(inst[6:0] == cpu_types_pkg::OPCODE_OP ||
			inst[6:0] == cpu_types_pkg::OPCODE_OP_IMM ||
			inst[6:0] == cpu_types_pkg::OPCODE_LUI);
	endfunction

	function automatic logic [31:0] model_result(input logic [31:0] inst,
		input logic [31:0] a, input logic [31:0] reg_b);
		logic [31:0] b;
		logic [4:0] shamt;
		logic alt;
		if (inst[6:0] == cpu_types_pkg::OPCODE_LUI) begin
			return {inst[31:12], 12'b0};
		end
		if (inst[6:0] == cpu_types_pkg::OPCODE_OP) begin
			b = reg_b;
		end else if (inst[6:0] == cpu_types_pkg::OPCODE_OP_IMM) begin
			b = {{20{inst[31]}}, inst[31:20]};
		end else begin
			return '0;
		end
		shamt = b[4:0];
		alt = inst[30];
		case (inst[14:12])
			3'd0: return (inst[6:0] == cpu_types_pkg::OPCODE_OP && alt) ? a - b : a + b;
			3'd1: return a << shamt;
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $unsigned($signed(a) >>> shamt);
				end
				return a >> shamt;
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// ##############################
	// checks.
	// ##############################

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
			stop_with_failure("first mismatch found, stopping");
		end
	endtask

	task automatic check_row(input int r);
		check_value($sformatf("row %0d result", r), dut_result, exp_result[r]);
		check_value($sformatf("row %0d rd", r), 32'(dut_rd), 32'(exp_rd[r]));
		check_value($sformatf("row %0d illegal", r), 32'(dut_illegal), 32'(exp_illegal[r]));
		check_value($sformatf("row %0d tag", r), 32'(dut_tag), 32'(exp_tag[r]));
	endtask

	always @(negedge clock) begin
		if (i_cpu_operand_stage.u_registers.u_chk.failures != 0) begin
			stop_with_failure("a register file assertion failed");
		end
	end

	// ##############################
	// stimulus table.
	// ##############################

	task automatic add_row(input logic [31:0] inst, input logic wb_new,
		input cpu_types_pkg::reg_index_t rd, input logic [31:0] value);
		if (row_count >= MAX_ROWS) begin
			stop_with_failure("stimulus table is full");
		end
		row_inst[row_count] = inst;
		row_wb_new[row_count] = wb_new;
		row_wb_rd[row_count] = rd;
		row_wb_value[row_count] = value;
		row_count++;
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [31:0] value;
		logic [31:0] inst;
		logic [11:0] imm12;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [2:0] kind;
		logic alt;
		// stack pointer after reset and zero in every other register.
		add_row(make_i_type(12'd0, 5'd2, cpu_types_pkg::FUNCT3_ADD_SUB, 5'd5), 1'b0, '0, '0);
		for (int r = 3; r <= 31; r += 2) begin
			inst = make_r_type(cpu_types_pkg::FUNCT7_BASE, 5'((r == 31) ? 1 : r + 1), 5'(r),
				cpu_types_pkg::FUNCT3_OR, 5'd7);
			add_row(inst, 1'b0, '0, '0);
		end
		// writes to x8..x13, each row reading the previous write.
		for (int k = 0; k < 6; k++) begin
			draw_random(value);
			inst = make_r_type(cpu_types_pkg::FUNCT7_BASE, 5'd0, 5'(7 + k),
				cpu_types_pkg::FUNCT3_ADD_SUB, 5'd20);
			add_row(inst, 1'b1, 5'(8 + k), value);
		end
		for (int k = 0; k < 6; k++) begin
			inst = make_r_type(cpu_types_pkg::FUNCT7_BASE, 5'd0, 5'(8 + k),
				cpu_types_pkg::FUNCT3_ADD_SUB, 5'd20);
			add_row(inst, 1'b0, '0, '0);
		end
		// a repeated tag leaves x8 unchanged.
		draw_random(value);
		inst = make_r_type(cpu_types_pkg::FUNCT7_BASE, 5'd0, 5'd8,
			cpu_types_pkg::FUNCT3_ADD_SUB, 5'd21);
		add_row(inst, 1'b0, 5'd8, value);
		add_row(inst, 1'b0, '0, '0);
		// write to x0 is dropped.
		inst = make_r_type(cpu_types_pkg::FUNCT7_BASE, 5'd0, 5'd0,
			cpu_types_pkg::FUNCT3_ADD_SUB, 5'd22);
		add_row(inst, 1'b1, 5'd0, 32'hdead_beef);
		add_row(inst, 1'b0, '0, '0);
		add_row(make_r_type(cpu_types_pkg::FUNCT7_BASE, 5'd9, 5'd0, cpu_types_pkg::FUNCT3_OR,
			5'd23), 1'b0, '0, '0);
		// random operands in x14..x19.
		for (int k = 0; k < 6; k++) begin
			draw_random(value);
			add_row(make_i_type(12'(k), 5'(8 + k), cpu_types_pkg::FUNCT3_ADD_SUB, 5'd24), 1'b1,
				5'(14 + k), value);
		end
		for (int k = 0; k < 24; k++) begin
			draw_random(rnd);
			draw_random(rnd2);
			f3 = rnd[13:11];
			alt = rnd[14];
			kind = rnd[17:15];
			if (kind < 3'd4) begin
				f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ?
					cpu_types_pkg::FUNCT7_ALT : cpu_types_pkg::FUNCT7_BASE;
				inst = make_r_type(f7, SOURCES[rnd[5:3]], SOURCES[rnd[2:0]], f3, rnd[10:6]);
			end else if (kind < 3'd7) begin
				if (f3 == 3'd1 || f3 == 3'd5) begin
					imm12 = {(alt && f3 == 3'd5) ? cpu_types_pkg::FUNCT7_ALT :
						cpu_types_pkg::FUNCT7_BASE, rnd2[24:20]};
				end else begin
					imm12 = rnd2[31:20];
				end
				inst = make_i_type(imm12, SOURCES[rnd[2:0]], f3, rnd[10:6]);
			end else begin
				inst = make_lui(rnd2[31:12], rnd[10:6]);
			end
			if (rnd[18]) begin
				draw_random(value);
				add_row(inst, 1'b1, SOURCES[rnd[21:19]], value);
			end else begin
				add_row(inst, 1'b0, '0, '0);
			end
		end
		// unsupported opcodes with normal instructions right behind them.
		add_row(make_store(5'd14, 5'd2, 12'h7f4), 1'b0, '0, '0);
		add_row(make_i_type(12'd16, 5'd2, cpu_types_pkg::FUNCT3_ADD_SUB, 5'd9), 1'b0, '0, '0);
		add_row(make_store(5'd15, 5'd16, 12'h010), 1'b0, '0, '0);
		add_row(make_r_type(cpu_types_pkg::FUNCT7_ALT, 5'd15, 5'd16,
			cpu_types_pkg::FUNCT3_ADD_SUB, 5'd25), 1'b0, '0, '0);
	endtask

	// expected values use the registers before this row's write lands.
	task automatic apply_row(input int r);
		logic [31:0] inst;
		inst = row_inst[r];
		exp_illegal[r] = model_illegal(inst);
		exp_rd[r] = exp_illegal[r] ? 5'd0 : inst[11:7];
		exp_result[r] = model_result(inst, model_regs[inst[19:15]], model_regs[inst[24:20]]);
		exp_tag[r] = r[1:0];
		fetch_inst = inst;
		fetch_tag = r[1:0];
		wb_rd = row_wb_rd[r];
		wb_value = row_wb_value[r];
		if (row_wb_new[r]) begin
			wb_tag = wb_tag + 1'b1;
			if (row_wb_rd[r] != '0) begin
				model_regs[row_wb_rd[r]] = row_wb_value[r];
			end
		end
	endtask

	// ##############################
	// main sequence.
	// ##############################

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		fetch_inst = '0;
		fetch_tag = '0;
		wb_rd = '0;
		wb_value = '0;
		wb_tag = '0;
		rng_state = 32'h13fd;
		row_count = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = (i == 2) ? STACK_POINTER : '0;
		end
		build_table();

		fork
			begin
				#((row_count * 20 + RESET_CYCLES) * CLOCK_PERIOD);
				stop_with_failure("timeout, the run took longer than the table allows");
			end
		join_none

		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;

		// results come out two edges after their row.
		for (int c = 0; c < row_count + 2; c++) begin
			@(posedge clock);
			#DRIVE_DELAY;
			if (c >= 2) begin
				check_row(c - 2);
			end
			if (c < row_count) begin
				apply_row(c);
			end
		end

		if (i_cpu_operand_stage.u_registers.u_chk.failures != 0) begin
			stop_with_failure("a register file assertion failed");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// File: compile.f
common/cpu_types_pkg.sv
registers/cpu_registers.sv
decode/cpu_immediate.sv
source/cpu_execute.sv
source/cpu_operand_stage.sv
verif/cpu_operand_stage_chk.sv
verif/cpu_operand_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the operand stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f compile.f \
	--top-module cpu_operand_stage_tb \
	-o sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0
